/* source/board_pkg.sv */
/*
 * board register map
 * register offsets, address page value, version words and the
 * opcode types passed from the address decoder to the datapath
 */
package board_pkg;

    // ----------------------------------------------------------
    // address fields
    // ----------------------------------------------------------
    localparam logic [3:0] ADDR_MAIN = 4'h0;    // bits 15:12, board page

    // register offsets, address bits 3:0
    localparam logic [3:0] REG_STATUS   = 4'd0;
    localparam logic [3:0] REG_PHYCTRL  = 4'd1;
    localparam logic [3:0] REG_PHYDATA  = 4'd2;
    localparam logic [3:0] REG_TIMEOUT  = 4'd3;
    localparam logic [3:0] REG_VERSION  = 4'd4;
    localparam logic [3:0] REG_TEMPSNS  = 4'd5;
    localparam logic [3:0] REG_DIGIOUT  = 4'd6;
    localparam logic [3:0] REG_FVERSION = 4'd7;
    localparam logic [3:0] REG_PROMSTAT = 4'd8;
    localparam logic [3:0] REG_PROMRES  = 4'd9;
    localparam logic [3:0] REG_DIGIN    = 4'd10;

    // version words
    localparam logic [31:0] VERSION_WORD    = 32'h514c_4131;  // "QLA1"
    localparam logic [31:0] FW_VERSION_WORD = 32'h0000_0004;

    // ----------------------------------------------------------
    // bus opcodes
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        WR_NONE, WR_STATUS, WR_PHYCTRL, WR_PHYDATA, WR_TIMEOUT, WR_DIGIOUT
    } wr_op_e;

    // one select per readable offset, same encoding as the offset
    typedef enum logic [3:0] {
        RD_STATUS, RD_PHYCTRL, RD_PHYDATA, RD_TIMEOUT, RD_VERSION, RD_TEMPSNS,
        RD_DIGIOUT, RD_FVERSION, RD_PROMSTAT, RD_PROMRES, RD_DIGIN,
        RD_ZERO = 4'hf
    } rd_sel_e;

endpackage

/* source/safety_pkg.sv */
/*
 * safety definitions
 * axis count, watchdog and settle timer widths, settle states
 */
package safety_pkg;

    localparam int NUM_AXES = 4;    // axes on this board
    localparam int WDOG_W   = 16;   // watchdog period / counter
    localparam int MV_CNT_W = 16;   // settle tick counter

    // motor-voltage settle machine
    typedef enum logic [1:0] {
        MV_OFF,         // supply not good, amps held off
        MV_SETTLE,      // supply good, blanking running
        MV_GOOD         // blanking done
    } mv_state_e;

endpackage

/* source/reg_bus_if.sv */
/*
 * decoded register access
 * carries the write opcode, write data and read select from the
 * address decoder to the control and read-back blocks
 */
`timescale 1ns/1ps

interface reg_bus_if;
    import board_pkg::*;

    wr_op_e      wr_op;       // WR_NONE unless a main-page write
    logic [31:0] wdata;       // raw host write data
    rd_sel_e     rd_sel;      // decoded read offset
    logic        any_write;   // host strobe, any address

    modport decoder (
        output wr_op, wdata, rd_sel, any_write
    );

    // control registers and watchdog clear
    modport executor (
        input wr_op, wdata, any_write
    );

    // read mux, holds on writes
    modport reader (
        input rd_sel, wr_op
    );

endinterface

/* source/ctrl_state_if.sv */
/*
 * control and safety state
 * register state from the control block and timer state from the
 * safety timers, gathered for the read-back mux
 */
`timescale 1ns/1ps

interface ctrl_state_if;
    import safety_pkg::*;

    logic [NUM_AXES-1:0] reg_disable;        // host amp disables
    logic                pwr_enable;
    logic                relay_on;
    logic [NUM_AXES-1:0] dout;               // digital outputs
    logic [15:0]         phy_ctrl;           // scratch
    logic [15:0]         phy_data;           // scratch
    logic [WDOG_W-1:0]   wdog_period;
    logic                wdog_timeout;
    logic [NUM_AXES-1:0] wdog_amp_disable;
    logic [NUM_AXES-1:0] mv_amp_disable;     // settle blanking

    modport exec_side (
        output reg_disable, pwr_enable, relay_on, dout, phy_ctrl, phy_data, wdog_period,
        input  wdog_amp_disable
    );

    modport timer_side (
        output wdog_timeout, wdog_amp_disable, mv_amp_disable,
        input  wdog_period
    );

    modport read_side (
        input reg_disable, pwr_enable, relay_on, dout, phy_ctrl, phy_data,
        input wdog_period, wdog_timeout
    );

endinterface

/* source/reg_decode.sv */
/*
 * register address decoder
 * sorts host write address and strobe into a write opcode and the
 * read address into a read select, both purely combinational
 */
`timescale 1ns/1ps

module reg_decode (
    input  logic [15:0] reg_waddr,
    input  logic [15:0] reg_raddr,
    input  logic [31:0] reg_wdata,
    input  logic        reg_wen,
    reg_bus_if.decoder  bus
);
    import board_pkg::*;

    logic wr_page;  // write hits board page
    logic rd_page;  // read hits board page

    assign wr_page = (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[7:4] == 4'd0);
    assign rd_page = (reg_raddr[15:12] == ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    assign bus.wdata     = reg_wdata;
    assign bus.any_write = reg_wen;     // watchdog clear, any address

    // write opcode, writable offsets only
    always_comb begin
        bus.wr_op = WR_NONE;
        if (reg_wen && wr_page) begin
            case (reg_waddr[3:0])
                REG_STATUS:  bus.wr_op = WR_STATUS;
                REG_PHYCTRL: bus.wr_op = WR_PHYCTRL;
                REG_PHYDATA: bus.wr_op = WR_PHYDATA;
                REG_TIMEOUT: bus.wr_op = WR_TIMEOUT;
                REG_DIGIOUT: bus.wr_op = WR_DIGIOUT;
                default:     bus.wr_op = WR_NONE;    // prom etc, not ours
            endcase
        end
    end

    // read select, anything unknown reads zero
    always_comb begin
        bus.rd_sel = RD_ZERO;
        if (rd_page && (reg_raddr[3:0] <= REG_DIGIN)) begin
            bus.rd_sel = rd_sel_e'(reg_raddr[3:0]);  // select encoding = offset
        end
    end

endmodule

/* source/board_ctrl_exec.sv */
/*
 * board control registers
 * applies masked host writes to amp enables, relay, power and
 * digital outputs, holds phy scratch and watchdog period, latches
 * amp disables on watchdog or safety faults, raises soft reset
 */
`timescale 1ns/1ps

module board_ctrl_exec (
    input  logic                              sysclk,
    input  logic                              reset,
    input  logic [safety_pkg::NUM_AXES-1:0]   safety_amp_disable,
    reg_bus_if.executor                       bus,
    ctrl_state_if.exec_side                   state,
    output logic                              soft_reset_req
);
    import board_pkg::*;
    import safety_pkg::*;

    logic [NUM_AXES-1:0] dis_next;    // status write result
    logic [NUM_AXES-1:0] dout_next;   // digout write result
    logic                fault_hit;   // any fault disable pending

    // ----------------------------------------------------------
    // masked write values
    // ----------------------------------------------------------
    // bits 11:8 are the masks for data bits 3:0
    always_comb begin
        for (int i = 0; i < NUM_AXES; i++) begin
            // power off forces the amp disabled
            dis_next[i]  = ~state.pwr_enable |
                           (bus.wdata[8+i] ? ~bus.wdata[i] : state.reg_disable[i]);
            dout_next[i] = bus.wdata[8+i] ? bus.wdata[i] : state.dout[i];
        end
    end

    assign fault_hit = (|state.wdog_amp_disable) || (|safety_amp_disable);

    // ----------------------------------------------------------
    // register file
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            state.reg_disable <= '1;            // all amps off
            state.pwr_enable  <= 1'b0;
            state.relay_on    <= 1'b0;
            state.dout        <= '0;
            state.phy_ctrl    <= '0;
            state.phy_data    <= '0;
            state.wdog_period <= '1;            // armed, long period
            soft_reset_req    <= 1'b0;
        end else begin
            soft_reset_req <= 1'b0;             // pulse by default
            case (bus.wr_op)
                WR_STATUS: begin
                    state.reg_disable <= dis_next;
                    // relay 17 masks 16
                    state.relay_on   <= bus.wdata[17] ? bus.wdata[16] : state.relay_on;
                    // power 19 masks 18
                    state.pwr_enable <= bus.wdata[19] ? bus.wdata[18] : state.pwr_enable;
                    // soft reset 21 masks 20, one cycle only
                    soft_reset_req   <= bus.wdata[21] & bus.wdata[20] & ~soft_reset_req;
                end
                WR_PHYCTRL: state.phy_ctrl    <= bus.wdata[15:0];
                WR_PHYDATA: state.phy_data    <= bus.wdata[15:0];
                WR_TIMEOUT: state.wdog_period <= bus.wdata[WDOG_W-1:0];
                WR_DIGIOUT: state.dout        <= dout_next;
                default: begin
                    // no board write, latch fault disables
                    if (fault_hit) begin
                        state.reg_disable <= state.reg_disable |
                                             state.wdog_amp_disable |
                                             safety_amp_disable;
                    end
                end
            endcase
        end
    end

endmodule

/* source/safety_timers.sv */
/*
 * safety timers
 * divides sysclk into a watchdog tick, runs the host watchdog that
 * any register write clears, and blanks the amps while the motor
 * supply settles after mv_good rises
 */
`timescale 1ns/1ps

module safety_timers #(
    parameter int WDOG_DIV_WIDTH  = 8,      // tick every 2**n clocks
    parameter int MV_SETTLE_TICKS = 7680    // blanking length in ticks
) (
    input  logic              sysclk,
    input  logic              reset,
    input  logic              mv_good,
    reg_bus_if.executor       bus,
    ctrl_state_if.timer_side  state
);
    import safety_pkg::*;

    logic [WDOG_DIV_WIDTH-1:0] div_cnt;   // tick prescaler
    logic                      tick;
    logic [WDOG_W-1:0]         wdog_cnt;  // ticks since last write
    logic [MV_CNT_W-1:0]       mv_cnt;    // settle ticks so far
    mv_state_e                 mv_state;

    // ----------------------------------------------------------
    // tick divider
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) div_cnt <= '0;
        else        div_cnt <= div_cnt + 1'b1;
    end

    assign tick = &div_cnt;     // last count of each period

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset || bus.any_write) begin
            wdog_cnt               <= '0;       // host is alive
            state.wdog_timeout     <= 1'b0;
            state.wdog_amp_disable <= '0;
        end else if (tick && (state.wdog_period != '0)) begin
            if (wdog_cnt < state.wdog_period) begin
                wdog_cnt <= wdog_cnt + 1'b1;
            end else begin
                state.wdog_timeout     <= 1'b1;  // sticky until a write
                state.wdog_amp_disable <= '1;
            end
        end
    end

    // ----------------------------------------------------------
    // motor voltage settle
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (!reset) begin
            mv_state <= MV_OFF;
            mv_cnt   <= '0;
        end else if (!mv_good) begin
            mv_state <= MV_OFF;                 // supply lost, start over
            mv_cnt   <= '0;
        end else begin
            case (mv_state)
                MV_OFF:    mv_state <= MV_SETTLE;
                MV_SETTLE: begin
                    if (tick) begin
                        if (mv_cnt == MV_CNT_W'(MV_SETTLE_TICKS - 1)) mv_state <= MV_GOOD;
                        else mv_cnt <= mv_cnt + 1'b1;
                    end
                end
                default:   mv_state <= MV_GOOD; // hold
            endcase
        end
    end

    // amps blanked until settled
    assign state.mv_amp_disable = (mv_state == MV_GOOD) ? '0 : '1;

endmodule

/* source/reg_readback.sv */
/*
 * register read-back
 * builds the status and digital input words and registers the word
 * picked by the read select, holding it across board writes
 */
`timescale 1ns/1ps

module reg_readback (
    input  logic                            sysclk,
    input  logic                            reset,
    input  logic [3:0]                      board_id,      // rotary switch
    input  logic [15:0]                     temp_sense,
    input  logic [safety_pkg::NUM_AXES-1:0] neg_limit,
    input  logic [safety_pkg::NUM_AXES-1:0] pos_limit,
    input  logic [safety_pkg::NUM_AXES-1:0] home,
    input  logic [safety_pkg::NUM_AXES-1:0] fault,
    input  logic                            relay,         // relay feedback
    input  logic                            mv_good,
    input  logic                            v_fault,
    input  logic [safety_pkg::NUM_AXES-1:0] safety_amp_disable,
    input  logic [31:0]                     prom_status,
    input  logic [31:0]                     prom_result,
    reg_bus_if.reader                       bus,
    ctrl_state_if.read_side                 state,
    output logic [31:0]                     reg_rdata
);
    import board_pkg::*;
    import safety_pkg::*;

    logic [31:0] status_word;
    logic [31:0] digin_word;
    logic [31:0] rd_word;       // selected, before the register

    assign status_word = {4'(NUM_AXES), board_id,                     // byte 3
                          state.wdog_timeout, 3'd0,                   // byte 2
                          mv_good, state.pwr_enable, ~relay, state.relay_on,
                          4'd0, fault,                                // byte 1
                          safety_amp_disable, ~state.reg_disable};    // byte 0, 1 = on

    assign digin_word = {15'd0, v_fault, state.dout, neg_limit, pos_limit, home};

    always_comb begin
        case (bus.rd_sel)
            RD_STATUS:   rd_word = status_word;
            RD_PHYCTRL:  rd_word = {16'd0, state.phy_ctrl};
            RD_PHYDATA:  rd_word = {16'd0, state.phy_data};
            RD_TIMEOUT:  rd_word = 32'(state.wdog_period);
            RD_VERSION:  rd_word = VERSION_WORD;
            RD_TEMPSNS:  rd_word = {16'd0, temp_sense};
            RD_DIGIOUT:  rd_word = 32'(state.dout);
            RD_FVERSION: rd_word = FW_VERSION_WORD;
            RD_PROMSTAT: rd_word = prom_status;
            RD_PROMRES:  rd_word = prom_result;
            RD_DIGIN:    rd_word = digin_word;
            default:     rd_word = 32'd0;
        endcase
    end

    always_ff @(posedge sysclk) begin
        if (!reset) reg_rdata <= '0;
        else if (bus.wr_op == WR_NONE) reg_rdata <= rd_word;   // hold on board write
    end

endmodule

/* source/board_regs_top.sv */
/*
 * board register block, top level
 * host register access, control registers, watchdog and settle
 * blanking for a four-axis motor controller
 */
`timescale 1ns/1ps

module board_regs_top #(
    parameter int WDOG_DIV_WIDTH  = 8,
    parameter int MV_SETTLE_TICKS = 7680    // ~40 ms at default tick
) (
    input  logic                            sysclk,
    input  logic                            reset,
    // host register port
    input  logic [15:0]                     reg_raddr,
    input  logic [15:0]                     reg_waddr,
    input  logic [31:0]                     reg_wdata,
    input  logic                            reg_wen,
    output logic [31:0]                     reg_rdata,
    // board inputs
    input  logic [3:0]                      board_id,
    input  logic [15:0]                     temp_sense,
    input  logic [safety_pkg::NUM_AXES-1:0] neg_limit,
    input  logic [safety_pkg::NUM_AXES-1:0] pos_limit,
    input  logic [safety_pkg::NUM_AXES-1:0] home,
    input  logic [safety_pkg::NUM_AXES-1:0] fault,
    input  logic                            relay,
    input  logic                            mv_good,
    input  logic                            v_fault,
    input  logic [safety_pkg::NUM_AXES-1:0] safety_amp_disable,
    input  logic [31:0]                     prom_status,
    input  logic [31:0]                     prom_result,
    // board outputs
    output logic [safety_pkg::NUM_AXES-1:0] amp_disable,
    output logic [safety_pkg::NUM_AXES-1:0] dout,
    output logic                            pwr_enable,
    output logic                            relay_on,
    output logic                            soft_reset_req
);

    reg_bus_if    bus ();
    ctrl_state_if state ();

    reg_decode u_decode (
        .reg_waddr, .reg_raddr, .reg_wdata, .reg_wen, .bus(bus.decoder)
    );

    board_ctrl_exec u_exec (
        .sysclk, .reset, .safety_amp_disable,
        .bus(bus.executor), .state(state.exec_side), .soft_reset_req
    );

    safety_timers #(
        .WDOG_DIV_WIDTH(WDOG_DIV_WIDTH), .MV_SETTLE_TICKS(MV_SETTLE_TICKS)
    ) u_timers (
        .sysclk, .reset, .mv_good, .bus(bus.executor), .state(state.timer_side)
    );

    reg_readback u_readback (
        .sysclk, .reset, .board_id, .temp_sense, .neg_limit, .pos_limit, .home, .fault,
        .relay, .mv_good, .v_fault, .safety_amp_disable, .prom_status, .prom_result,
        .bus(bus.reader), .state(state.read_side), .reg_rdata
    );

    // host disables or settle blanking
    assign amp_disable = state.reg_disable | state.mv_amp_disable;
    assign dout        = state.dout;
    assign pwr_enable  = state.pwr_enable;
    assign relay_on    = state.relay_on;

endmodule

/* verif/board_regs_sva.sv */
/*
 * control block assertions
 * soft reset pulse width, amp disable forcing on power-off status
 * writes and disable latching on watchdog expiry
 */
`timescale 1ns/1ps

module board_regs_sva (
    input logic                            sysclk,
    input logic                            reset,
    input board_pkg::wr_op_e               wr_op,
    input logic                            any_write,
    input logic                            pwr_enable,
    input logic [safety_pkg::NUM_AXES-1:0] reg_disable,
    input logic [safety_pkg::NUM_AXES-1:0] wdog_amp_disable,
    input logic                            soft_reset_req
);
    import board_pkg::*;

    int fail_count = 0;     // assertion failures so far

    // single-cycle request
    assert property (@(posedge sysclk) disable iff (!reset)
        soft_reset_req |=> !soft_reset_req)
        else begin
            $error("soft_reset_req high for two cycles");
            fail_count++;
        end

    // status write with power off leaves every amp disabled
    assert property (@(posedge sysclk) disable iff (!reset)
        (!pwr_enable && (wr_op == WR_STATUS)) |=> (reg_disable == '1))
        else begin
            $error("reg_disable not forced by a status write with power off");
            fail_count++;
        end

    // watchdog expiry latches into the host disables
    assert property (@(posedge sysclk) disable iff (!reset)
        ((|wdog_amp_disable) && !any_write) |=> (reg_disable == '1))
        else begin
            $error("reg_disable not latched after watchdog expiry");
            fail_count++;
        end

endmodule

bind board_ctrl_exec board_regs_sva u_sva (
    .sysclk, .reset, .wr_op(bus.wr_op), .any_write(bus.any_write),
    .pwr_enable(state.pwr_enable), .reg_disable(state.reg_disable),
    .wdog_amp_disable(state.wdog_amp_disable), .soft_reset_req
);

/* verif/board_regs_tb.sv */
/*
 * board register block testbench
 * random host traffic and board inputs from a fixed seed against a
 * cycle model of the registers and timers, checked every cycle,
 * then directed settle, soft reset and watchdog runs
 */
`timescale 1ns/1ps

module board_regs_tb;
    import board_pkg::*;

    localparam int DIV_W        = 2;    // tick every 4 clocks
    localparam int SETTLE_TICKS = 8;

    logic        sysclk, reset, reg_wen, relay, mv_good, v_fault;
    logic [15:0] reg_raddr, reg_waddr, temp_sense;
    logic [31:0] reg_wdata, reg_rdata, prom_status, prom_result;
    logic [3:0]  board_id, neg_limit, pos_limit, home, fault, safety_amp_disable;
    logic [3:0]  amp_disable, dout;
    logic        pwr_enable, relay_on, soft_reset_req;

    // expected state
    logic [3:0]       m_dis, m_dout, m_wdis;
    logic             m_pwr, m_relay, m_srst, m_wto;
    logic [15:0]      m_phyc, m_phyd, m_period, m_wcnt;
    logic [DIV_W-1:0] m_div;
    logic [31:0]      m_rdata;
    int               m_mvst, m_mvticks;    // 0 off, 1 settling, 2 good
    integer           seed = 46;
    int               check_count = 0;
    int               error_count = 0;
    bit               checks_on = 0;

    board_regs_top #(.WDOG_DIV_WIDTH(DIV_W), .MV_SETTLE_TICKS(SETTLE_TICKS)) DUT (.*);

    initial begin
        sysclk = 1'b0;
        forever #2 sysclk = ~sysclk;
    end

    function automatic logic on_page(input logic [15:0] a);
        return (a[15:12] == ADDR_MAIN) && (a[7:4] == 4'h0);
    endfunction

    // mostly board page with the odd address anywhere
    function automatic logic [15:0] pick_addr(input logic [31:0] r);
        return (r[4:0] == 5'd0) ? r[31:16] : {ADDR_MAIN, r[15:12], 4'h0, r[11:8]};
    endfunction

    function automatic logic [31:0] read_word(input logic [15:0] a);
        if (!on_page(a)) return 32'h0;
        case (a[3:0])
            REG_STATUS:   return {4'd4, board_id, m_wto, 3'b000, mv_good, m_pwr, ~relay,
                                  m_relay, 4'h0, fault, safety_amp_disable, ~m_dis};
            REG_PHYCTRL:  return {16'h0, m_phyc};
            REG_PHYDATA:  return {16'h0, m_phyd};
            REG_TIMEOUT:  return {16'h0, m_period};
            REG_VERSION:  return VERSION_WORD;
            REG_TEMPSNS:  return {16'h0, temp_sense};
            REG_DIGIOUT:  return {28'h0, m_dout};
            REG_FVERSION: return FW_VERSION_WORD;
            REG_PROMSTAT: return prom_status;
            REG_PROMRES:  return prom_result;
            REG_DIGIN:    return {15'h0, v_fault, m_dout, neg_limit, pos_limit, home};
            default:      return 32'h0;
        endcase
    endfunction

    // ----------------------------------------------------------
    // cycle model on pre-edge inputs and state
    // ----------------------------------------------------------
    always @(posedge sysclk) begin : cycle_model
        int          code;          // 0 none, else offset + 1
        logic        tick;
        logic        srst_old;
        logic [3:0]  wdis_old;
        logic [15:0] period_old;
        code       = (reg_wen && on_page(reg_waddr)) ? reg_waddr[3:0] + 1 : 0;
        tick       = &m_div;
        srst_old   = m_srst;
        wdis_old   = m_wdis;
        period_old = m_period;
        if (!reset) begin
            {m_pwr, m_relay, m_srst, m_wto} = '0;
            {m_dout, m_wdis, m_div} = '0;
            {m_phyc, m_phyd, m_wcnt, m_rdata} = '0;
            m_dis     = 4'hf;
            m_period  = 16'hffff;
            m_mvst    = 0;
            m_mvticks = 0;
        end else begin
            if (!(code inside {1, 2, 3, 4, 7})) m_rdata = read_word(reg_raddr);
            m_srst = 1'b0;
            case (code)
                1: begin
                    for (int i = 0; i < 4; i++) begin
                        if (!m_pwr) m_dis[i] = 1'b1;        // power off forces it
                        else if (reg_wdata[8+i]) m_dis[i] = ~reg_wdata[i];
                    end
                    if (reg_wdata[17]) m_relay = reg_wdata[16];
                    if (reg_wdata[19]) m_pwr = reg_wdata[18];
                    m_srst = reg_wdata[21] & reg_wdata[20] & ~srst_old;
                end
                2: m_phyc = reg_wdata[15:0];
                3: m_phyd = reg_wdata[15:0];
                4: m_period = reg_wdata[15:0];
                7: begin
                    for (int i = 0; i < 4; i++) begin
                        if (reg_wdata[8+i]) m_dout[i] = reg_wdata[i];
                    end
                end
                default: m_dis = m_dis | wdis_old | safety_amp_disable;  // fault latch
            endcase
            if (reg_wen) begin                      // any write on any page
                m_wcnt = '0;
                m_wto  = 1'b0;
                m_wdis = 4'h0;
            end else if (tick && (period_old != 16'h0)) begin
                if (m_wcnt < period_old) m_wcnt = m_wcnt + 1'b1;
                else {m_wto, m_wdis} = 5'h1f;
            end
            if (!mv_good) begin
                m_mvst    = 0;
                m_mvticks = 0;
            end else if (m_mvst == 0) begin
                m_mvst = 1;
            end else if ((m_mvst == 1) && tick) begin
                m_mvticks++;
                if (m_mvticks == SETTLE_TICKS) m_mvst = 2;
            end
            m_div = m_div + 1'b1;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        check_count++;
        assert (got === exp) else begin
            error_count++;
            $display("ERROR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
        end
    endtask

    always @(negedge sysclk) begin
        if (checks_on) begin
            compare_value("reg_rdata", reg_rdata, m_rdata);
            compare_value("amp_disable", amp_disable, m_dis | ((m_mvst == 2) ? 4'h0 : 4'hf));
            compare_value("dout", dout, m_dout);
            compare_value("pwr_enable", pwr_enable, m_pwr);
            compare_value("relay_on", relay_on, m_relay);
            compare_value("soft_reset_req", soft_reset_req, m_srst);
        end
    end

    task automatic timeout_fail(input string what);
        error_count += DUT.u_exec.u_sva.fail_count + 1;
        $display("timed out: %s", what);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        $display("Checks failed");
        $finish;
    endtask

    task automatic write_reg(input logic [3:0] offset, input logic [31:0] data);
        @(posedge sysclk);
        reg_waddr <= {ADDR_MAIN, 8'h00, offset};
        reg_wdata <= data;
        reg_wen   <= 1'b1;
        @(posedge sysclk);
        reg_wen   <= 1'b0;
    endtask

    // 0 all amps on, 1 timeout bit read, 2 all amps off, 3 timeout bit gone
    task automatic wait_for_event(input int what, input string desc);
        int waited;
        bit done;
        waited = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge sysclk);
            case (what)
                0:       done = (amp_disable == 4'h0);
                1:       done = reg_rdata[23];
                2:       done = (amp_disable == 4'hf);
                default: done = !reg_rdata[23];
            endcase
            waited++;
            if (!done && (waited > 200)) timeout_fail(desc);
        end
    endtask

    initial begin
        logic [31:0] r;
        int          pulses;
        reset   = 1'b0;
        reg_wen = 1'b0;
        {reg_raddr, reg_waddr, reg_wdata, temp_sense, prom_status, prom_result} = '0;
        {board_id, neg_limit, pos_limit, home, fault, safety_amp_disable} = '0;
        {relay, mv_good, v_fault} = '0;
        repeat (2) @(posedge sysclk);
        reset <= 1'b1;
        @(negedge sysclk);                          // still reset values
        compare_value("reg_rdata", reg_rdata, 32'h0);
        compare_value("amp_disable", amp_disable, 32'hf);
        compare_value("pwr_enable,relay_on,dout,soft_reset_req",
                      {pwr_enable, relay_on, dout, soft_reset_req}, 32'h0);
        checks_on = 1'b1;

        // ----------------------------------------------------------
        // random traffic
        // ----------------------------------------------------------
        repeat (400) begin
            @(posedge sysclk);
            r = $random(seed);
            reg_wen            <= r[0];
            reg_waddr          <= pick_addr($random(seed));
            reg_raddr          <= pick_addr($random(seed));
            reg_wdata          <= $random(seed);
            board_id           <= r[7:4];
            neg_limit          <= r[11:8];
            pos_limit          <= r[15:12];
            home               <= r[19:16];
            fault              <= r[23:20];
            relay              <= r[24];
            v_fault            <= r[25];
            mv_good            <= (r[31:26] != 6'd0);   // rare supply drop
            safety_amp_disable <= (r[5:1] == 5'd0) ? r[11:8] : 4'h0;
            temp_sense         <= $random(seed);
            prom_status        <= $random(seed);
            prom_result        <= $random(seed);
        end

        // directed runs with a quiet host
        @(posedge sysclk);
        reg_wen            <= 1'b0;
        reg_raddr          <= {ADDR_MAIN, 8'h00, REG_STATUS};
        safety_amp_disable <= 4'h0;
        mv_good            <= 1'b0;
        write_reg(REG_TIMEOUT, 32'h0);              // watchdog off
        write_reg(REG_STATUS, 32'h000c_0000);       // power on
        write_reg(REG_STATUS, 32'h0000_0f0f);       // all amps on
        @(posedge sysclk);
        mv_good <= 1'b1;
        wait_for_event(0, "settle blanking never ended");

        write_reg(REG_STATUS, 32'h0030_0000);       // soft reset only
        pulses = 0;
        for (int i = 0; i < 6; i++) begin
            @(negedge sysclk);
            if (i == 0) compare_value("soft_reset_req", soft_reset_req, 32'h1);
            pulses += soft_reset_req;
        end
        compare_value("soft_reset_req pulses", pulses, 32'd1);

        write_reg(REG_TIMEOUT, 32'h3);              // short period then silence
        wait_for_event(1, "watchdog timeout never showed in the status word");
        wait_for_event(2, "watchdog did not disable the amplifiers");
        write_reg(REG_PHYCTRL, 32'h0000_1234);
        wait_for_event(3, "watchdog timeout not cleared by a write");
        repeat (4) @(negedge sysclk);

        error_count += DUT.u_exec.u_sva.fail_count;     // bound assertion failures
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* src.f */
source/board_pkg.sv
source/safety_pkg.sv
source/reg_bus_if.sv
source/ctrl_state_if.sv
source/reg_decode.sv
source/board_ctrl_exec.sv
source/safety_timers.sv
source/reg_readback.sv
source/board_regs_top.sv
verif/board_regs_sva.sv
verif/board_regs_tb.sv
